// ==== lcCtrl_pkg.sv ====
package lcCtrl_pkg;

  // --------------------------------------------------
  // Encoded life cycle state
  // --------------------------------------------------

  // Every later state sets one more bit of the OTP word, so each forward
  // transition only ever sets bits
  typedef enum logic [31:0] {
    LcStRaw           = 32'h0000_0000,
    LcStTestUnlocked0 = 32'h0000_0001,
    LcStTestLocked0   = 32'h0000_0003,
    LcStTestUnlocked1 = 32'h0000_0007,
    LcStTestLocked1   = 32'h0000_000F,
    LcStTestUnlocked2 = 32'h0000_001F,
    LcStTestLocked2   = 32'h0000_003F,
    LcStTestUnlocked3 = 32'h0000_007F,
    LcStTestLocked3   = 32'h0000_00FF,
    LcStTestUnlocked4 = 32'h0000_01FF,
    LcStTestLocked4   = 32'h0000_03FF,
    LcStTestUnlocked5 = 32'h0000_07FF,
    LcStTestLocked5   = 32'h0000_0FFF,
    LcStTestUnlocked6 = 32'h0000_1FFF,
    LcStTestLocked6   = 32'h0000_3FFF,
    LcStTestUnlocked7 = 32'h0000_7FFF,
    LcStDev           = 32'h0000_FFFF,
    LcStProd          = 32'h0001_FFFF,
    LcStProdEnd       = 32'h0003_FFFF,
    LcStRma           = 32'h0007_FFFF,
    LcStScrap         = 32'h000F_FFFF
  } lcState_e;

  // Thermometer coded transition counter, LcCntK has the lowest K bits set
  typedef enum logic [23:0] {
    LcCnt0  = 24'h00_0000, LcCnt1  = 24'h00_0001, LcCnt2  = 24'h00_0003,
    LcCnt3  = 24'h00_0007, LcCnt4  = 24'h00_000F, LcCnt5  = 24'h00_001F,
    LcCnt6  = 24'h00_003F, LcCnt7  = 24'h00_007F, LcCnt8  = 24'h00_00FF,
    LcCnt9  = 24'h00_01FF, LcCnt10 = 24'h00_03FF, LcCnt11 = 24'h00_07FF,
    LcCnt12 = 24'h00_0FFF, LcCnt13 = 24'h00_1FFF, LcCnt14 = 24'h00_3FFF,
    LcCnt15 = 24'h00_7FFF, LcCnt16 = 24'h00_FFFF, LcCnt17 = 24'h01_FFFF,
    LcCnt18 = 24'h03_FFFF, LcCnt19 = 24'h07_FFFF, LcCnt20 = 24'h0F_FFFF,
    LcCnt21 = 24'h1F_FFFF, LcCnt22 = 24'h3F_FFFF, LcCnt23 = 24'h7F_FFFF,
    LcCnt24 = 24'hFF_FFFF
  } lcCnt_e;

  // --------------------------------------------------
  // Decoded state index
  // --------------------------------------------------

  localparam int NumLcStates = 21;
  localparam int DecLcStateWidth = 5;
  localparam int DecLcStateNumRep = 2;

  // Indices above DecLcStScrap do not name a state
  typedef enum logic [DecLcStateWidth-1:0] {
    DecLcStRaw, DecLcStTestUnlocked0, DecLcStTestLocked0, DecLcStTestUnlocked1,
    DecLcStTestLocked1, DecLcStTestUnlocked2, DecLcStTestLocked2, DecLcStTestUnlocked3,
    DecLcStTestLocked3, DecLcStTestUnlocked4, DecLcStTestLocked4, DecLcStTestUnlocked5,
    DecLcStTestLocked5, DecLcStTestUnlocked6, DecLcStTestLocked6, DecLcStTestUnlocked7,
    DecLcStDev, DecLcStProd, DecLcStProdEnd, DecLcStRma, DecLcStScrap
  } decLcState_e;

  // Two copies of the decoded index, checked against each other downstream
  typedef logic [DecLcStateNumRep-1:0][DecLcStateWidth-1:0] extDecLcState_t;

  typedef enum logic [2:0] {
    IdleSt, CntIncrSt, CntProgSt, TransCheckSt,
    TokenCheck0St, TokenCheck1St, TransProgSt, DoneSt
  } fsmState_e;

  // --------------------------------------------------
  // Tokens and transition matrix
  // --------------------------------------------------

  typedef enum logic [2:0] {
    ZeroTokenIdx, RawUnlockTokenIdx, TestUnlockTokenIdx,
    TestExitTokenIdx, RmaTokenIdx, InvalidTokenIdx
  } tokenIdx_e;

  // Plain token values, one per token index
  localparam logic [31:0] TokenValue [6] = '{
    32'h0000_0000, 32'h1F2E_3D4C, 32'h7A6B_5C4D,
    32'h0E1D_2C3B, 32'h9182_7364, 32'hFFFF_FFFF
  };

  // First index is the source state and second index the target state
  typedef tokenIdx_e [NumLcStates-1:0][NumLcStates-1:0] transMatrix_t;

  function automatic transMatrix_t genTransMatrix();
    transMatrix_t m;
    bit srcTu;
    bit srcTl;
    bit tgtTu;
    bit tgtTl;
    for (int s = 0; s < NumLcStates; s++) begin
      for (int t = 0; t < NumLcStates; t++) begin
        // Unlocked test states sit on odd indices and locked ones on even indices
        srcTu = s >= 1 && s <= 15 && (s % 2) == 1;
        srcTl = s >= 2 && s <= 14 && (s % 2) == 0;
        tgtTu = t >= 1 && t <= 15 && (t % 2) == 1;
        tgtTl = t >= 2 && t <= 14 && (t % 2) == 0;
        m[s][t] = InvalidTokenIdx;
        if (t == DecLcStScrap && s < t)
          m[s][t] = ZeroTokenIdx;
        else if (s == DecLcStRaw && tgtTu)
          m[s][t] = RawUnlockTokenIdx;
        else if (srcTu && tgtTl && t > s)
          m[s][t] = ZeroTokenIdx;
        else if (srcTl && tgtTu && t > s)
          m[s][t] = TestUnlockTokenIdx;
        else if ((srcTu || srcTl) && t >= DecLcStDev && t <= DecLcStProdEnd)
          m[s][t] = TestExitTokenIdx;
        else if (srcTu && t == DecLcStRma)
          m[s][t] = ZeroTokenIdx;
        else if ((s == DecLcStDev || s == DecLcStProd) && t == DecLcStRma)
          m[s][t] = RmaTokenIdx;
      end
    end
    return m;
  endfunction

  localparam transMatrix_t TransTokenIdxMatrix = genTransMatrix();

endpackage

// ==== lcStateDecode.sv ====
`timescale 1ns/1ns

module lcStateDecode import lcCtrl_pkg::*; (
  input  lcState_e       lcState_i,
  output extDecLcState_t decLcState_o,
  output logic           stateInvalid_o
);

  logic [DecLcStateWidth-1:0] decIdx;

  // Only the 21 exact encodings are accepted and any partly programmed word is invalid
  always_comb begin
    stateInvalid_o = 1'b0;
    unique case (lcState_i)
      LcStRaw:           decIdx = DecLcStRaw;
      LcStTestUnlocked0: decIdx = DecLcStTestUnlocked0;
      LcStTestLocked0:   decIdx = DecLcStTestLocked0;
      LcStTestUnlocked1: decIdx = DecLcStTestUnlocked1;
      LcStTestLocked1:   decIdx = DecLcStTestLocked1;
      LcStTestUnlocked2: decIdx = DecLcStTestUnlocked2;
      LcStTestLocked2:   decIdx = DecLcStTestLocked2;
      LcStTestUnlocked3: decIdx = DecLcStTestUnlocked3;
      LcStTestLocked3:   decIdx = DecLcStTestLocked3;
      LcStTestUnlocked4: decIdx = DecLcStTestUnlocked4;
      LcStTestLocked4:   decIdx = DecLcStTestLocked4;
      LcStTestUnlocked5: decIdx = DecLcStTestUnlocked5;
      LcStTestLocked5:   decIdx = DecLcStTestLocked5;
      LcStTestUnlocked6: decIdx = DecLcStTestUnlocked6;
      LcStTestLocked6:   decIdx = DecLcStTestLocked6;
      LcStTestUnlocked7: decIdx = DecLcStTestUnlocked7;
      LcStDev:           decIdx = DecLcStDev;
      LcStProd:          decIdx = DecLcStProd;
      LcStProdEnd:       decIdx = DecLcStProdEnd;
      LcStRma:           decIdx = DecLcStRma;
      LcStScrap:         decIdx = DecLcStScrap;
      default: begin
        // All ones lies above DecLcStScrap and fails every bounds check
        decIdx = '1;
        stateInvalid_o = 1'b1;
      end
    endcase
  end

  // Both replicas carry the same index
  assign decLcState_o = {DecLcStateNumRep{decIdx}};

endmodule

// ==== lcStateTransition.sv ====
`timescale 1ns/1ns

module lcStateTransition import lcCtrl_pkg::*; #(
  parameter bit SecVolatileRawUnlockEn = 1'b0
) (
  input  lcState_e       lcState_i,
  input  lcCnt_e         lcCnt_i,
  input  fsmState_e      fsmState_i,
  input  extDecLcState_t decLcState_i,
  input  extDecLcState_t transTarget_i,
  input  logic           volatileRawUnlock_i,
  input  logic           transCmd_i,
  output lcState_e       nextLcState_o,
  output lcCnt_e         nextLcCnt_o,
  output logic           transCntOflwError_o,
  output logic           transInvalidError_o
);

  logic [23:0] cntVec;
  logic        idxValid;

  assign cntVec = lcCnt_i;

  // Both replicas of source and target must agree and name a real state
  // before they may index the matrix, which also rejects a bad source encoding
  assign idxValid = decLcState_i[0] == decLcState_i[1] &&
                    transTarget_i[0] == transTarget_i[1] &&
                    decLcState_i[0] <= DecLcStScrap &&
                    transTarget_i[0] <= DecLcStScrap;

  always_comb begin
    nextLcCnt_o = lcCnt_i;
    nextLcState_o = lcState_i;
    transCntOflwError_o = 1'b0;
    transInvalidError_o = 1'b0;

    // --------------------------------------------------
    // Volatile RAW unlock
    // --------------------------------------------------
    // Checked on the command strobe itself since this path never leaves IdleSt
    if (SecVolatileRawUnlockEn && volatileRawUnlock_i && transCmd_i && fsmState_i == IdleSt) begin
      // Raw to TestUnlocked0 is the only edge this path may take
      if (decLcState_i != {DecLcStateNumRep{DecLcStRaw}} ||
          transTarget_i != {DecLcStateNumRep{DecLcStTestUnlocked0}}) begin
        transInvalidError_o = 1'b1;
      end
    end

    // --------------------------------------------------
    // Counter increment
    // --------------------------------------------------
    // The incremented value stays asserted through the later steps so that
    // the store always sees a consistent next counter
    if (fsmState_i inside {CntIncrSt, CntProgSt, TransCheckSt,
                           TokenCheck0St, TokenCheck1St, TransProgSt}) begin
      // A thermometer word has no set bit above a clear one
      if (lcCnt_i == LcCnt24 || (cntVec & (cntVec + 24'd1)) != 24'd0) begin
        transCntOflwError_o = 1'b1;
      end else begin
        nextLcCnt_o = lcCnt_e'({cntVec[22:0], 1'b1});
      end
      // Scrap is always reachable, so the counter is maxed out and the
      // state already forced to Scrap to keep the silenced overflow harmless
      if (transTarget_i == {DecLcStateNumRep{DecLcStScrap}}) begin
        nextLcCnt_o = LcCnt24;
        nextLcState_o = LcStScrap;
        transCntOflwError_o = 1'b0;
      end
    end

    // --------------------------------------------------
    // Edge check and target encoding
    // --------------------------------------------------
    if (fsmState_i inside {TransCheckSt, TokenCheck0St, TokenCheck1St, TransProgSt}) begin
      if (!idxValid) begin
        transInvalidError_o = 1'b1;
      end else if (TransTokenIdxMatrix[decLcState_i[0]][transTarget_i[0]] == InvalidTokenIdx ||
                   TransTokenIdxMatrix[decLcState_i[1]][transTarget_i[1]] == InvalidTokenIdx) begin
        transInvalidError_o = 1'b1;
      end else begin
        // Even a wrong encoding here cannot clear bits, the store would refuse it
        unique case (transTarget_i[0])
          DecLcStRaw:           nextLcState_o = LcStRaw;
          DecLcStTestUnlocked0: nextLcState_o = LcStTestUnlocked0;
          DecLcStTestLocked0:   nextLcState_o = LcStTestLocked0;
          DecLcStTestUnlocked1: nextLcState_o = LcStTestUnlocked1;
          DecLcStTestLocked1:   nextLcState_o = LcStTestLocked1;
          DecLcStTestUnlocked2: nextLcState_o = LcStTestUnlocked2;
          DecLcStTestLocked2:   nextLcState_o = LcStTestLocked2;
          DecLcStTestUnlocked3: nextLcState_o = LcStTestUnlocked3;
          DecLcStTestLocked3:   nextLcState_o = LcStTestLocked3;
          DecLcStTestUnlocked4: nextLcState_o = LcStTestUnlocked4;
          DecLcStTestLocked4:   nextLcState_o = LcStTestLocked4;
          DecLcStTestUnlocked5: nextLcState_o = LcStTestUnlocked5;
          DecLcStTestLocked5:   nextLcState_o = LcStTestLocked5;
          DecLcStTestUnlocked6: nextLcState_o = LcStTestUnlocked6;
          DecLcStTestLocked6:   nextLcState_o = LcStTestLocked6;
          DecLcStTestUnlocked7: nextLcState_o = LcStTestUnlocked7;
          DecLcStDev:           nextLcState_o = LcStDev;
          DecLcStProd:          nextLcState_o = LcStProd;
          DecLcStProdEnd:       nextLcState_o = LcStProdEnd;
          DecLcStRma:           nextLcState_o = LcStRma;
          DecLcStScrap:         nextLcState_o = LcStScrap;
          default:              transInvalidError_o = 1'b1;
        endcase
      end
    end
  end

endmodule

// ==== lcOtpModel.sv ====
`timescale 1ns/1ns

module lcOtpModel import lcCtrl_pkg::*; #(
  parameter lcState_e InitLcState = LcStRaw,
  parameter lcCnt_e   InitLcCnt   = LcCnt0
) (
  input  logic     clk_i,
  input  logic     arstN_i,
  input  logic     cntWr_i,
  input  lcCnt_e   cntWrData_i,
  input  logic     stateWr_i,
  input  lcState_e stateWrData_i,
  output lcState_e lcState_o,
  output lcCnt_e   lcCnt_o,
  output logic     wrError_o
);

  lcState_e lcStateQ;
  lcCnt_e   lcCntQ;
  logic     cntClears;
  logic     stateClears;

  // A write is illegal when the new word drops any bit that is already set
  assign cntClears = (cntWrData_i & lcCntQ) != lcCntQ;
  assign stateClears = (stateWrData_i & lcStateQ) != lcStateQ;

  // Flagged in the same cycle as the write strobe
  assign wrError_o = (cntWr_i && cntClears) || (stateWr_i && stateClears);

  // The partition comes up holding the programmed contents
  always_ff @(posedge clk_i or negedge arstN_i) begin
    if (!arstN_i) begin
      lcStateQ <= InitLcState;
      lcCntQ <= InitLcCnt;
    end else begin
      // A refused write leaves the word as it was
      if (cntWr_i && !cntClears) begin
        lcCntQ <= cntWrData_i;
      end
      if (stateWr_i && !stateClears) begin
        lcStateQ <= stateWrData_i;
      end
    end
  end

  assign lcState_o = lcStateQ;
  assign lcCnt_o = lcCntQ;

  // Counter and state are programmed in separate FSM steps
  assert property (@(posedge clk_i) disable iff (!arstN_i) !(cntWr_i && stateWr_i))
    else $error("counter and state written in the same cycle");

endmodule

// ==== lcCtrlFsm.sv ====
`timescale 1ns/1ns

module lcCtrlFsm import lcCtrl_pkg::*; #(
  parameter bit SecVolatileRawUnlockEn = 1'b0
) (
  input  logic           clk_i,
  input  logic           arstN_i,
  input  logic           transCmd_i,
  input  decLcState_e    transTarget_i,
  input  logic [31:0]    transToken_i,
  input  logic           volatileRawUnlock_i,
  input  lcState_e       otpLcState_i,
  input  extDecLcState_t decLcState_i,
  input  logic           stateInvalid_i,
  input  logic           cntOflwError_i,
  input  logic           transInvalidError_i,
  input  logic           otpWrError_i,
  output fsmState_e      fsmState_o,
  output extDecLcState_t transTargetRep_o,
  output logic           otpCntWr_o,
  output logic           otpStateWr_o,
  output lcState_e       lcState_o,
  output logic           busy_o,
  output logic           transDone_o,
  output logic           cntOflwError_o,
  output logic           transInvalidError_o,
  output logic           tokenError_o,
  output logic           otpError_o,
  output logic           stateInvalid_o
);

  fsmState_e                  fsmStateQ;
  fsmState_e                  fsmStateD;
  logic [DecLcStateWidth-1:0] targetQ;
  logic [31:0]                tokenQ;
  logic [31:0]                expToken0;
  logic [31:0]                expToken1;
  logic                       cmdAccept;
  logic                       cntOflwSet;
  logic                       transInvSet;
  logic                       tokenSet;
  logic                       otpSet;
  logic                       volatileSet;
  logic                       cntOflwErrQ;
  logic                       transInvErrQ;
  logic                       tokenErrQ;
  logic                       otpErrQ;
  logic                       volatileQ;
  logic                       stateInvalidQ;

  // Commands are only taken while idle and any strobe during a walk is dropped
  assign cmdAccept = fsmStateQ == IdleSt && transCmd_i;

  // While idle the live target is replicated so the volatile edge check can run on the strobe
  // Afterwards the registered copy is used
  assign transTargetRep_o = {DecLcStateNumRep{(fsmStateQ == IdleSt) ? transTarget_i : targetQ}};

  // Each token step looks up the matrix through its own replica
  assign expToken0 = TokenValue[TransTokenIdxMatrix[decLcState_i[0]][transTargetRep_o[0]]];
  assign expToken1 = TokenValue[TransTokenIdxMatrix[decLcState_i[1]][transTargetRep_o[1]]];

  // --------------------------------------------------
  // Step sequencing
  // --------------------------------------------------
  always_comb begin
    fsmStateD = fsmStateQ;
    otpCntWr_o = 1'b0;
    otpStateWr_o = 1'b0;
    cntOflwSet = 1'b0;
    transInvSet = 1'b0;
    tokenSet = 1'b0;
    otpSet = 1'b0;
    volatileSet = 1'b0;
    unique case (fsmStateQ)
      IdleSt: begin
        if (transCmd_i && SecVolatileRawUnlockEn && volatileRawUnlock_i) begin
          // Volatile unlock finishes in one step and never touches the store
          fsmStateD = DoneSt;
          if (transInvalidError_i)
            transInvSet = 1'b1;
          else if (transToken_i != TokenValue[RawUnlockTokenIdx])
            tokenSet = 1'b1;
          else
            volatileSet = 1'b1;
        end else if (transCmd_i) begin
          fsmStateD = CntIncrSt;
        end
      end
      CntIncrSt: begin
        cntOflwSet = cntOflwError_i;
        fsmStateD = cntOflwError_i ? DoneSt : CntProgSt;
      end
      CntProgSt: begin
        // The counter is burnt before the edge is even checked
        otpCntWr_o = 1'b1;
        otpSet = otpWrError_i;
        fsmStateD = otpWrError_i ? DoneSt : TransCheckSt;
      end
      TransCheckSt: begin
        transInvSet = transInvalidError_i;
        fsmStateD = transInvalidError_i ? DoneSt : TokenCheck0St;
      end
      TokenCheck0St: begin
        tokenSet = tokenQ != expToken0;
        fsmStateD = tokenSet ? DoneSt : TokenCheck1St;
      end
      TokenCheck1St: begin
        tokenSet = tokenQ != expToken1;
        fsmStateD = tokenSet ? DoneSt : TransProgSt;
      end
      TransProgSt: begin
        otpStateWr_o = 1'b1;
        otpSet = otpWrError_i;
        fsmStateD = DoneSt;
      end
      // DoneSt lasts one cycle and carries the done pulse
      default: fsmStateD = IdleSt;
    endcase
  end

  always_ff @(posedge clk_i or negedge arstN_i) begin
    if (!arstN_i) begin
      fsmStateQ <= IdleSt;
      cntOflwErrQ <= 1'b0;
      transInvErrQ <= 1'b0;
      tokenErrQ <= 1'b0;
      otpErrQ <= 1'b0;
      volatileQ <= 1'b0;
      stateInvalidQ <= 1'b0;
    end else begin
      fsmStateQ <= fsmStateD;
      stateInvalidQ <= stateInvalid_i;
      // A new command drops the previous result and otherwise errors accumulate
      if (cmdAccept) begin
        cntOflwErrQ <= cntOflwSet;
        transInvErrQ <= transInvSet;
        tokenErrQ <= tokenSet;
        otpErrQ <= otpSet;
      end else begin
        cntOflwErrQ <= cntOflwErrQ | cntOflwSet;
        transInvErrQ <= transInvErrQ | transInvSet;
        tokenErrQ <= tokenErrQ | tokenSet;
        otpErrQ <= otpErrQ | otpSet;
      end
      // Only a reset leaves the volatile unlock
      if (volatileSet) begin
        volatileQ <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (cmdAccept) begin
      targetQ <= transTarget_i;
      tokenQ <= transToken_i;
    end
  end

  assign fsmState_o = fsmStateQ;
  assign busy_o = fsmStateQ != IdleSt;
  assign transDone_o = fsmStateQ == DoneSt;
  assign lcState_o = volatileQ ? LcStTestUnlocked0 : otpLcState_i;
  assign cntOflwError_o = cntOflwErrQ;
  assign transInvalidError_o = transInvErrQ;
  assign tokenError_o = tokenErrQ;
  assign otpError_o = otpErrQ;
  assign stateInvalid_o = stateInvalidQ;

  // The store is only written while the command in flight has recorded no error
  assert property (@(posedge clk_i) disable iff (!arstN_i)
    (otpCntWr_o || otpStateWr_o) |-> !(cntOflwErrQ || transInvErrQ || tokenErrQ || otpErrQ))
    else $error("store written after an error was recorded");

endmodule

// ==== lcCtrl.sv ====
`timescale 1ns/1ns

module lcCtrl import lcCtrl_pkg::*; #(
  parameter bit       SecVolatileRawUnlockEn = 1'b0,
  parameter lcState_e InitLcState            = LcStRaw,
  parameter lcCnt_e   InitLcCnt              = LcCnt0
) (
  input  logic        clk_i,
  input  logic        arstN_i,
  input  logic        transCmd_i,
  input  decLcState_e transTarget_i,
  input  logic [31:0] transToken_i,
  input  logic        volatileRawUnlock_i,
  output lcState_e    lcState_o,
  output lcCnt_e      lcCnt_o,
  output logic        busy_o,
  output logic        transDone_o,
  output logic        cntOflwError_o,
  output logic        transInvalidError_o,
  output logic        tokenError_o,
  output logic        otpError_o,
  output logic        stateInvalid_o
);

  lcState_e       otpState;
  lcCnt_e         otpCnt;
  extDecLcState_t decState;
  logic           stateInvalid;
  lcState_e       nextState;
  lcCnt_e         nextCnt;
  logic           cntOflwErr;
  logic           transInvalidErr;
  fsmState_e      fsmState;
  extDecLcState_t transTargetRep;
  logic           otpCntWr;
  logic           otpStateWr;
  logic           otpWrErr;

  // Store contents reach the outside untouched, the FSM adds the volatile override
  assign lcCnt_o = otpCnt;

  lcOtpModel #(
    .InitLcState(InitLcState),
    .InitLcCnt  (InitLcCnt)
  ) u_lcOtpModel (
    .clk_i        (clk_i),
    .arstN_i      (arstN_i),
    .cntWr_i      (otpCntWr),
    .cntWrData_i  (nextCnt),
    .stateWr_i    (otpStateWr),
    .stateWrData_i(nextState),
    .lcState_o    (otpState),
    .lcCnt_o      (otpCnt),
    .wrError_o    (otpWrErr)
  );

  lcStateDecode u_lcStateDecode (
    .lcState_i     (otpState),
    .decLcState_o  (decState),
    .stateInvalid_o(stateInvalid)
  );

  lcStateTransition #(
    .SecVolatileRawUnlockEn(SecVolatileRawUnlockEn)
  ) u_lcStateTransition (
    .lcState_i          (otpState),
    .lcCnt_i            (otpCnt),
    .fsmState_i         (fsmState),
    .decLcState_i       (decState),
    .transTarget_i      (transTargetRep),
    .volatileRawUnlock_i(volatileRawUnlock_i),
    .transCmd_i         (transCmd_i),
    .nextLcState_o      (nextState),
    .nextLcCnt_o        (nextCnt),
    .transCntOflwError_o(cntOflwErr),
    .transInvalidError_o(transInvalidErr)
  );

  lcCtrlFsm #(
    .SecVolatileRawUnlockEn(SecVolatileRawUnlockEn)
  ) u_lcCtrlFsm (
    .clk_i              (clk_i),
    .arstN_i            (arstN_i),
    .transCmd_i         (transCmd_i),
    .transTarget_i      (transTarget_i),
    .transToken_i       (transToken_i),
    .volatileRawUnlock_i(volatileRawUnlock_i),
    .otpLcState_i       (otpState),
    .decLcState_i       (decState),
    .stateInvalid_i     (stateInvalid),
    .cntOflwError_i     (cntOflwErr),
    .transInvalidError_i(transInvalidErr),
    .otpWrError_i       (otpWrErr),
    .fsmState_o         (fsmState),
    .transTargetRep_o   (transTargetRep),
    .otpCntWr_o         (otpCntWr),
    .otpStateWr_o       (otpStateWr),
    .lcState_o          (lcState_o),
    .busy_o             (busy_o),
    .transDone_o        (transDone_o),
    .cntOflwError_o     (cntOflwError_o),
    .transInvalidError_o(transInvalidError_o),
    .tokenError_o       (tokenError_o),
    .otpError_o         (otpError_o),
    .stateInvalid_o     (stateInvalid_o)
  );

endmodule

// ==== lcCtrl_tb.sv ====
`timescale 1ns/1ns

module lcCtrl_tb import lcCtrl_pkg::*; ();

  localparam int ResetCycles = 10;
  localparam int NumResets = 3;
  localparam int NumCmds = 11;
  // Each command gets a wide budget on top of the reset phases
  localparam int TimeoutCycles = 200 * NumCmds + ResetCycles * NumResets;

  logic        clk_i;
  logic        arstN_i;
  logic        transCmd_i;
  decLcState_e transTarget_i;
  logic [31:0] transToken_i;
  logic        volatileRawUnlock_i;
  lcState_e    lcState_o;
  lcCnt_e      lcCnt_o;
  logic        busy_o;
  logic        transDone_o;
  logic        cntOflwError_o;
  logic        transInvalidError_o;
  logic        tokenError_o;
  logic        otpError_o;
  logic        stateInvalid_o;

  // Model of the store contents and the volatile unlock flag
  int          mState;
  int          mCnt;
  bit          mVol;
  // Expected result of the command in flight, bits are {otp, token, edge, overflow}
  int          expState;
  int          expCnt;
  int          expLat;
  bit          expVol;
  logic [3:0]  expErrs;
  int          errCount;
  int          checkCount;
  int          cycleCount;
  int          waitCycles;
  bit          armed;
  bit          afterDone;
  integer      seed;

  lcCtrl #(
    .SecVolatileRawUnlockEn(1'b1),
    .InitLcState           (LcStRaw),
    .InitLcCnt             (LcCnt0)
  ) u_lcCtrl (
    .clk_i              (clk_i),
    .arstN_i            (arstN_i),
    .transCmd_i         (transCmd_i),
    .transTarget_i      (transTarget_i),
    .transToken_i       (transToken_i),
    .volatileRawUnlock_i(volatileRawUnlock_i),
    .lcState_o          (lcState_o),
    .lcCnt_o            (lcCnt_o),
    .busy_o             (busy_o),
    .transDone_o        (transDone_o),
    .cntOflwError_o     (cntOflwError_o),
    .transInvalidError_o(transInvalidError_o),
    .tokenError_o       (tokenError_o),
    .otpError_o         (otpError_o),
    .stateInvalid_o     (stateInvalid_o)
  );

  always #10 clk_i = ~clk_i;

  // --------------------------------------------------
  // Reference model
  // --------------------------------------------------

  // Walks the enum in declaration order, which is the life cycle order
  function automatic lcState_e stateEnc(input int idx);
    lcState_e e;
    e = e.first();
    for (int i = 0; i < idx; i++) begin
      e = e.next();
    end
    return e;
  endfunction

  // Thermometer code with the lowest k bits set
  function automatic logic [23:0] cntEnc(input int k);
    return 24'((32'h1 << k) - 32'h1);
  endfunction

  function automatic void refModel(
    input  int          srcIdx,
    input  int          cnt,
    input  bit          curVol,
    input  int          tgtIdx,
    input  logic [31:0] tok,
    input  bit          vol,
    output int          nxtIdx,
    output int          nxtCnt,
    output bit          nxtVol,
    output logic [3:0]  errs,
    output int          lat
  );
    tokenIdx_e tokIdx;
    nxtIdx = srcIdx;
    nxtCnt = cnt;
    nxtVol = curVol;
    errs = 4'b0000;
    if (vol) begin
      // Volatile path finishes right away and leaves the store alone
      lat = 1;
      if (srcIdx != int'(DecLcStRaw) || tgtIdx != int'(DecLcStTestUnlocked0))
        errs[1] = 1'b1;
      else if (tok != TokenValue[RawUnlockTokenIdx])
        errs[2] = 1'b1;
      else
        nxtVol = 1'b1;
    end else if (tgtIdx != int'(DecLcStScrap) && cnt == 24) begin
      errs[0] = 1'b1;
      lat = 2;
    end else begin
      // From here on the counter is already programmed
      nxtCnt = (tgtIdx == int'(DecLcStScrap)) ? 24 : cnt + 1;
      tokIdx = TransTokenIdxMatrix[srcIdx][tgtIdx];
      if (tokIdx == InvalidTokenIdx) begin
        errs[1] = 1'b1;
        lat = 4;
      end else if (tok != TokenValue[tokIdx]) begin
        errs[2] = 1'b1;
        lat = 5;
      end else begin
        nxtIdx = tgtIdx;
        lat = 7;
      end
    end
  endfunction

  // --------------------------------------------------
  // Checking and run control
  // --------------------------------------------------

  task automatic reportMismatch(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
    errCount++;
    $display("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp);
  endtask

  task automatic endRun();
    $display("Checks: %0d, errors: %0d", checkCount, errCount);
    if (errCount == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  endtask

  // Outputs are sampled on the falling edge, away from the DUT's updates
  always @(negedge clk_i) begin
    if (afterDone) begin
      afterDone = 1'b0;
      if (transDone_o !== 1'b0) reportMismatch("transDone_o", transDone_o, 32'h0);
      if (busy_o !== 1'b0) reportMismatch("busy_o", busy_o, 32'h0);
    end
    if (armed) begin
      waitCycles++;
      if (busy_o !== 1'b1) reportMismatch("busy_o", busy_o, 32'h1);
      if (transDone_o === 1'b1) begin
        armed = 1'b0;
        afterDone = 1'b1;
        checkCount++;
        if (waitCycles != expLat) reportMismatch("latency", waitCycles, expLat);
        if (lcState_o !== stateEnc(expVol ? int'(DecLcStTestUnlocked0) : expState))
          reportMismatch("lcState_o", lcState_o,
                         stateEnc(expVol ? int'(DecLcStTestUnlocked0) : expState));
        if (lcCnt_o !== cntEnc(expCnt)) reportMismatch("lcCnt_o", lcCnt_o, cntEnc(expCnt));
        if (cntOflwError_o !== expErrs[0])
          reportMismatch("cntOflwError_o", cntOflwError_o, expErrs[0]);
        if (transInvalidError_o !== expErrs[1])
          reportMismatch("transInvalidError_o", transInvalidError_o, expErrs[1]);
        if (tokenError_o !== expErrs[2]) reportMismatch("tokenError_o", tokenError_o, expErrs[2]);
        if (otpError_o !== expErrs[3]) reportMismatch("otpError_o", otpError_o, expErrs[3]);
        if (stateInvalid_o !== 1'b0) reportMismatch("stateInvalid_o", stateInvalid_o, 32'h0);
      end
    end
  end

  always @(posedge clk_i) begin
    cycleCount++;
    if (cycleCount >= TimeoutCycles) begin
      errCount++;
      $display("Timeout after %0d cycles, a done pulse never arrived", cycleCount);
      endRun();
    end
  end

  // --------------------------------------------------
  // Stimulus
  // --------------------------------------------------

  task automatic applyReset();
    @(posedge clk_i);
    arstN_i <= 1'b0;
    repeat (ResetCycles) @(posedge clk_i);
    arstN_i <= 1'b1;
    // The store reloads its initial contents and the volatile flag drops
    mState = 0;
    mCnt = 0;
    mVol = 1'b0;
    @(negedge clk_i);
    checkCount++;
    if (lcState_o !== LcStRaw) reportMismatch("lcState_o", lcState_o, LcStRaw);
    if (lcCnt_o !== LcCnt0) reportMismatch("lcCnt_o", lcCnt_o, LcCnt0);
    if (busy_o !== 1'b0) reportMismatch("busy_o", busy_o, 32'h0);
    if (transDone_o !== 1'b0) reportMismatch("transDone_o", transDone_o, 32'h0);
    if (cntOflwError_o !== 1'b0) reportMismatch("cntOflwError_o", cntOflwError_o, 32'h0);
    if (transInvalidError_o !== 1'b0)
      reportMismatch("transInvalidError_o", transInvalidError_o, 32'h0);
    if (tokenError_o !== 1'b0) reportMismatch("tokenError_o", tokenError_o, 32'h0);
    if (otpError_o !== 1'b0) reportMismatch("otpError_o", otpError_o, 32'h0);
  endtask

  task automatic issueCmd(input decLcState_e tgt, input logic [31:0] tok, input bit vol);
    refModel(mState, mCnt, mVol, int'(tgt), tok, vol,
             expState, expCnt, expVol, expErrs, expLat);
    @(posedge clk_i);
    transCmd_i <= 1'b1;
    transTarget_i <= tgt;
    transToken_i <= tok;
    volatileRawUnlock_i <= vol;
    @(posedge clk_i);
    // The DUT samples the strobe on this edge and the latency counts from here
    transCmd_i <= 1'b0;
    volatileRawUnlock_i <= 1'b0;
    waitCycles = 0;
    armed = 1'b1;
    wait (!armed);
    mState = expState;
    mCnt = expCnt;
    mVol = expVol;
  endtask

  task automatic pickWrongToken(input logic [31:0] good, output logic [31:0] tok);
    tok = $random(seed);
    while (tok == good) begin
      tok = $random(seed);
    end
  endtask

  initial begin
    logic [31:0] badTok;
    clk_i = 1'b0;
    arstN_i = 1'b0;
    transCmd_i = 1'b0;
    transTarget_i = DecLcStRaw;
    transToken_i = 32'h0;
    volatileRawUnlock_i = 1'b0;
    errCount = 0;
    checkCount = 0;
    cycleCount = 0;
    waitCycles = 0;
    armed = 1'b0;
    afterDone = 1'b0;
    seed = 1320;
    applyReset();
    // Volatile unlock shows TestUnlocked0 until the next reset
    issueCmd(DecLcStTestUnlocked0, TokenValue[RawUnlockTokenIdx], 1'b1);
    applyReset();
    // Forward chain with the right token at each edge
    issueCmd(DecLcStTestUnlocked0, TokenValue[RawUnlockTokenIdx], 1'b0);
    issueCmd(DecLcStTestLocked0, TokenValue[ZeroTokenIdx], 1'b0);
    issueCmd(DecLcStDev, TokenValue[TestExitTokenIdx], 1'b0);
    // Wrong token, then a backwards edge, each still burns a count
    pickWrongToken(TokenValue[RmaTokenIdx], badTok);
    issueCmd(DecLcStRma, badTok, 1'b0);
    issueCmd(DecLcStTestLocked0, TokenValue[ZeroTokenIdx], 1'b0);
    issueCmd(DecLcStRma, TokenValue[RmaTokenIdx], 1'b0);
    // Scrap maxes out the counter so any further command overflows
    issueCmd(DecLcStScrap, TokenValue[ZeroTokenIdx], 1'b0);
    issueCmd(DecLcStRma, TokenValue[RmaTokenIdx], 1'b0);
    applyReset();
    issueCmd(DecLcStScrap, TokenValue[ZeroTokenIdx], 1'b0);
    issueCmd(DecLcStDev, TokenValue[TestExitTokenIdx], 1'b0);
    repeat (2) @(posedge clk_i);
    endRun();
  end

endmodule

// ==== lcCtrl.f ====
lcCtrl_pkg.sv
lcStateDecode.sv
lcStateTransition.sv
lcOtpModel.sv
lcCtrlFsm.sv
lcCtrl.sv
lcCtrl_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module lcCtrl_tb -f lcCtrl.f -o simv
./obj_dir/simv | tee sim.log

if grep -qF '** FAIL **' sim.log; then
  echo "Simulation reported failure"
  exit 1
fi
echo "Simulation finished without failure"
